//--- bench/vector_mem_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "vector_mem_params.svh"

module vector_mem_tb;

	// --------------------
	// Run length
	// --------------------

	// Upper bound on bus transactions, directed plus random
	localparam int TXN_COUNT   = 500;
	localparam int RANDOM_TXN  = 400;
	localparam int RESET_CYC   = 16;
	// Four clocks of 10 ns per transaction, plus reset and margin
	localparam int WATCHDOG_NS = TXN_COUNT * 4 * 10 + RESET_CYC * 10 + 2000;

	// DUT ports
	logic                  clk = 1'b0;
	logic                  reset;
	logic                  clke;
	logic [`VM_ADDR_W-1:0] address;
	logic [7:0]            wdata;
	logic                  memwr;
	logic                  memrd;
	logic                  stack;
	logic                  iowr;
	logic [7:0]            read_data;
	logic [7:0]            kvaz_debug;

	// --------------------
	// Reference model
	// --------------------

	// Control byte as last written to port 0x10
	logic [7:0]            model_ctrl;
	// Bytes keyed by full SRAM address
	logic [7:0]            model_mem [logic [`VM_SRAM_W-1:0]];
	// Expected result of the last read, valid only for written locations
	logic [7:0]            model_rd;
	logic                  model_rd_valid;
	// CPU addresses written so far, for reads that revisit them
	logic [`VM_ADDR_W-1:0] written_q [$];
	integer                seed;

	vector_mem_top DUT (
		.clk        (clk),
		.reset      (reset),
		.clke       (clke),
		.address    (address),
		.wdata      (wdata),
		.memwr      (memwr),
		.memrd      (memrd),
		.stack      (stack),
		.iowr       (iowr),
		.read_data  (read_data),
		.kvaz_debug (kvaz_debug)
	);

	always #5 clk = ~clk;

	// Page chosen for a CPU cycle
	// bit 7 high_ext, 6 low_ext, 5 window on, 4 stack on, 3:2 stack page, 1:0 window page
	function automatic logic [`VM_PAGE_W-1:0] model_page(
		input logic [7:0]            c,
		input logic [`VM_ADDR_W-1:0] a,
		input logic                  stk,
		input logic                  access
	);
		logic [3:0] nib;
		logic       hit;
		nib = a[`VM_ADDR_W-1 -: 4];
		hit = (nib >= 4'hA && nib <= 4'hD)
			|| ((nib == 4'h8 || nib == 4'h9) && c[6])
			|| (nib >= 4'hE && c[7]);
		if (access && stk && c[4]) begin
			return 3'(c[3:2]) + 3'd1;
		end else if (access && c[5] && hit) begin
			return 3'(c[1:0]) + 3'd1;
		end
		return '0;
	endfunction

	// --------------------
	// Failure reporting
	// --------------------

	task automatic fail_run(input string msg);
		$display("%s", msg);
		$display("TESTBENCH FAILED");
		$fatal(1, "simulation stopped");
	endtask

	task automatic value_error(input string name, input logic [7:0] exp, input logic [7:0] act);
		fail_run($sformatf("[ERROR] t=%0t %s expected %02h actual %02h", $time, name, exp, act));
	endtask

	// Control byte must follow the model on every edge
	// covers other ports and writes with clke low
	a_ctrl_track: assert property (@(posedge clk) disable iff (reset)
		kvaz_debug == model_ctrl)
		else value_error("kvaz_debug", $sampled(model_ctrl), $sampled(kvaz_debug));

	// Port write shows one edge later
	a_ctrl_load: assert property (@(posedge clk) disable iff (reset)
		(iowr && clke && address[7:0] == `VM_PORT_KVAZ) |=> (kvaz_debug == model_ctrl))
		else value_error("kvaz_debug", $sampled(model_ctrl), $sampled(kvaz_debug));

	// Read data registered one edge after the read
	a_read: assert property (@(posedge clk) disable iff (reset)
		(memrd && clke) |=> (!model_rd_valid || read_data == model_rd))
		else value_error("read_data", $sampled(model_rd), $sampled(read_data));

	// --------------------
	// Stimulus
	// --------------------

	// Model follows the DUT on the edge where the cycle takes effect
	task automatic update_model(
		input logic                  wr,
		input logic                  rd,
		input logic                  io,
		input logic                  stk,
		input logic [`VM_ADDR_W-1:0] a,
		input logic [7:0]            d
	);
		logic [`VM_SRAM_W-1:0] sa;
		sa = {model_page(model_ctrl, a, stk, wr | rd), a};
		if (io && a[7:0] == `VM_PORT_KVAZ) begin
			model_ctrl = d;
		end
		if (wr) begin
			model_mem[sa] = d;
			written_q.push_back(a);
		end
		if (rd) begin
			model_rd_valid = model_mem.exists(sa);
			model_rd       = model_rd_valid ? model_mem[sa] : 8'h00;
		end
	endtask

	// One bus cycle, then an idle cycle with clke low
	task automatic bus_cycle(
		input logic                  en,
		input logic                  wr,
		input logic                  rd,
		input logic                  io,
		input logic                  stk,
		input logic [`VM_ADDR_W-1:0] a,
		input logic [7:0]            d
	);
		@(posedge clk);
		clke    <= en;
		memwr   <= wr;
		memrd   <= rd;
		iowr    <= io;
		stack   <= stk;
		address <= a;
		wdata   <= d;
		@(posedge clk);
		if (en) begin
			update_model(wr, rd, io, stk, a, d);
		end
		clke  <= 1'b0;
		memwr <= 1'b0;
		memrd <= 1'b0;
		iowr  <= 1'b0;
		stack <= 1'b0;
	endtask

	task automatic port_write(input logic [7:0] port, input logic [7:0] d, input logic en);
		bus_cycle(en, 1'b0, 1'b0, 1'b1, 1'b0, {port, port}, d);
	endtask

	task automatic mem_write(input logic [`VM_ADDR_W-1:0] a, input logic [7:0] d, input logic stk);
		bus_cycle(1'b1, 1'b1, 1'b0, 1'b0, stk, a, d);
	endtask

	task automatic mem_read(input logic [`VM_ADDR_W-1:0] a, input logic stk);
		bus_cycle(1'b1, 1'b0, 1'b1, 1'b0, stk, a, 8'h00);
	endtask

	initial begin
		#(WATCHDOG_NS);
		fail_run("Watchdog expired: the stimulus did not finish in time, the bus looks hung");
	end

	initial begin
		int                    i;
		int                    wp;
		logic [31:0]           rnd;
		logic [`VM_ADDR_W-1:0] a;
		logic [7:0]            d;
		seed           = 32'h5edc;
		model_ctrl     = 8'h00;
		model_rd       = 8'h00;
		model_rd_valid = 1'b0;
		reset          = 1'b1;
		clke           = 1'b0;
		address        = '0;
		wdata          = 8'h00;
		memwr          = 1'b0;
		memrd          = 1'b0;
		stack          = 1'b0;
		iowr           = 1'b0;
		repeat (RESET_CYC) @(posedge clk);
		reset <= 1'b0;

		// Disk off, everything lands in main RAM
		mem_write(16'hA000, 8'h5a, 1'b0);
		mem_write(16'hC123, 8'h3c, 1'b0);
		mem_write(16'h8100, 8'h81, 1'b0);
		mem_write(16'hF000, 8'hf0, 1'b0);
		mem_write(16'h7fff, 8'h7f, 1'b0);
		mem_read(16'hA000, 1'b0);
		mem_read(16'hC123, 1'b0);

		// Only port 0x10 with clke high loads the register
		port_write(8'h10, 8'h21, 1'b1);
		port_write(8'h11, 8'hff, 1'b1);
		port_write(8'h00, 8'h96, 1'b1);
		port_write(8'h10, 8'h3c, 1'b0);
		port_write(8'h10, 8'h00, 1'b1);

		// Window on, each window page in turn
		for (wp = 0; wp < 4; wp++) begin
			port_write(8'h10, 8'h20 | 8'(wp), 1'b1);
			mem_write(16'hA000, 8'ha0 + 8'(wp), 1'b0);
			mem_write(16'hDFFF, 8'hd0 + 8'(wp), 1'b0);
			mem_read(16'hA000, 1'b0);
			mem_read(16'hDFFF, 1'b0);
			mem_read(16'h7fff, 1'b0);
		end
		// Window off reads old main RAM data
		port_write(8'h10, 8'h00, 1'b1);
		mem_read(16'hA000, 1'b0);
		mem_read(16'hC123, 1'b0);

		// Extended window on both sides
		port_write(8'h10, 8'he2, 1'b1);
		mem_write(16'h8100, 8'h18, 1'b0);
		mem_write(16'hF000, 8'h0f, 1'b0);
		mem_read(16'h8100, 1'b0);
		mem_read(16'hF000, 1'b0);
		// Extension bits clear, back to main RAM
		port_write(8'h10, 8'h22, 1'b1);
		mem_read(16'h8100, 1'b0);
		mem_read(16'hF000, 1'b0);

		// Stack page 3 over window page 1
		port_write(8'h10, 8'h3d, 1'b1);
		mem_write(16'hA000, 8'h55, 1'b1);
		mem_write(16'h2000, 8'h22, 1'b1);
		mem_read(16'hA000, 1'b1);
		mem_read(16'hA000, 1'b0);
		mem_read(16'h2000, 1'b1);
		// Stack off, stack cycles follow the window
		port_write(8'h10, 8'h21, 1'b1);
		mem_read(16'hA000, 1'b1);
		mem_read(16'h2000, 1'b1);

		// Mixed random traffic
		for (i = 0; i < RANDOM_TXN; i++) begin
			rnd = $random(seed);
			a   = $random(seed);
			d   = $random(seed);
			if (rnd[5]) begin
				a[15] = 1'b1;
			end
			case (rnd[1:0])
				2'd0: port_write(rnd[3] ? 8'h10 : a[7:0], d, 1'b1);
				2'd1: mem_write(a, d, rnd[2]);
				default: begin
					if (rnd[4] && written_q.size() > 0) begin
						a = written_q[$unsigned($random(seed)) % written_q.size()];
					end
					mem_read(a, rnd[2]);
				end
			endcase
		end

		repeat (3) @(posedge clk);
		$display("TESTBENCH PASSED");
		$finish;
	end

endmodule

`default_nettype wire

//--- include/vector_mem_params.svh
`ifndef VECTOR_MEM_PARAMS_SVH
`define VECTOR_MEM_PARAMS_SVH

// --------------------
// I/O map
// --------------------

// Quasi-disk control register sits at this I/O port
`define VM_PORT_KVAZ 8'h10

// --------------------
// Address space
// --------------------

// CPU address bus width
`define VM_ADDR_W 16

// Page number width, enough for main RAM plus four disk pages
`define VM_PAGE_W 3

// Number of 64 KB pages in SRAM
`define VM_PAGES 8

// Full SRAM address is page number on top of the CPU address
`define VM_SRAM_W (`VM_PAGE_W + `VM_ADDR_W)

`endif

//--- source/cpu_bus_decoder.sv
`timescale 1ns/1ps
`default_nettype none

`include "vector_mem_params.svh"

module cpu_bus_decoder
	import vector_mem_pkg::*;
(
	input  wire            clk,
	input  wire            reset,
	cpu_bus_if.decoder     bus,
	output logic           ctrl_load,
	output logic           sram_we,
	output logic           sram_re
);

	// --------------------
	// Port decode
	// --------------------

	// Port number is the low address byte
	io_port_t port_num;

	// Address matches the quasi-disk port
	logic     port_hit;

	assign port_num = bus.address[7:0];
	assign port_hit = (port_num == `VM_PORT_KVAZ);

	// Only an enabled phase lets the write through
	assign ctrl_load = bus.iowr & bus.clke & port_hit;

	// --------------------
	// Memory enables
	// --------------------

	// Write lands on the edge where the phase is active
	assign sram_we = bus.memwr & bus.clke;

	// Read data is captured on the same kind of edge
	assign sram_re = bus.memrd & bus.clke;

	// Page selection downstream uses the raw levels
	// so the page is already stable when these fire

endmodule

`default_nettype wire

//--- source/cpu_bus_if.sv
`timescale 1ns/1ps
`default_nettype none

`include "vector_mem_params.svh"

// CPU side of the memory subsystem
interface cpu_bus_if;

	// Active phase of the CPU clock
	logic                  clke;
	// Memory address, or port number in bits 7:0 on I/O
	logic [`VM_ADDR_W-1:0] address;
	// Data from the CPU
	logic [7:0]            wdata;
	// Memory strobes are levels and never both high
	logic                  memwr;
	logic                  memrd;
	// Set during push, pop, call and return cycles
	logic                  stack;
	// I/O write pulse
	logic                  iowr;

	// Strobe qualification and port decode
	modport decoder (
		input clke, address, memwr, memrd, iowr
	);

	// Register load data and page selection
	modport mapper (
		input address, wdata, memwr, memrd, stack
	);

	// Byte storage
	modport memory (
		input address, wdata
	);

endinterface

`default_nettype wire

//--- source/page_sram.sv
`timescale 1ns/1ps
`default_nettype none

`include "vector_mem_params.svh"

module page_sram
	import vector_mem_pkg::*;
(
	input  wire            clk,
	cpu_bus_if.memory      bus,
	input  page_t          page,
	input  wire            sram_we,
	input  wire            sram_re,
	output logic [7:0]     read_data,
	input  wire            reset
);

	// --------------------
	// Storage
	// --------------------

	// All pages back to back, one byte per location
	logic [7:0] mem [0:`VM_PAGES*(2**`VM_ADDR_W)-1];

	// Page on top, CPU address below
	sram_addr_t addr;

	assign addr = {page, bus.address};

	// --------------------
	// Write port
	// --------------------

	// Byte written on the enabled edge
	always_ff @(posedge clk) begin
		if (sram_we) begin
			mem[addr] <= bus.wdata;
		end
	end

	// --------------------
	// Read port
	// --------------------

	// Data captured on the read edge
	// holds until the next read
	always_ff @(posedge clk) begin
		if (reset) begin
			read_data <= 8'h00;
		end else if (sram_re) begin
			read_data <= mem[addr];
		end
	end

	// Read and write never overlap on the CPU bus
	// so no bypass from the write port is needed

endmodule

`default_nettype wire

//--- source/ram_disk_mapper.sv
`timescale 1ns/1ps
`default_nettype none

`include "vector_mem_params.svh"

module ram_disk_mapper
	import vector_mem_pkg::*;
(
	input  wire            clk,
	input  wire            reset,
	cpu_bus_if.mapper      bus,
	input  wire            ctrl_load,
	output page_t          page,
	output logic [7:0]     ctrl
);

	// --------------------
	// Control register
	// --------------------

	kvaz_ctrl_u ctrl_q;

	// Cleared control maps everything to main RAM
	always_ff @(posedge clk) begin
		if (reset) begin
			ctrl_q.raw <= 8'h00;
		end else if (ctrl_load) begin
			ctrl_q.raw <= bus.wdata;
		end
	end

	// Raw byte out for debug
	assign ctrl = ctrl_q.raw;

	// --------------------
	// Window decode
	// --------------------

	// Top nibble of the CPU address
	logic [3:0] adsel;

	// Address falls in the enabled window range
	logic       window_hit;

	assign adsel = bus.address[`VM_ADDR_W-1 -: 4];

	always_comb begin
		case (adsel)
			// Standard window 0xA000 to 0xDFFF
			4'hA, 4'hB, 4'hC, 4'hD: window_hit = 1'b1;
			// Lower extension 0x8000 to 0x9FFF
			4'h8, 4'h9:             window_hit = ctrl_q.f.low_ext;
			// Upper extension 0xE000 to 0xFFFF
			4'hE, 4'hF:             window_hit = ctrl_q.f.high_ext;
			default:                window_hit = 1'b0;
		endcase
	end

	// --------------------
	// Page select
	// --------------------

	// Any memory cycle in progress
	logic  mem_cycle;

	// Stack and window mapping requests
	logic  stack_sel;
	logic  window_sel;

	// Disk pages are offset by one past main RAM
	page_t stack_pg;
	page_t window_pg;

	assign mem_cycle  = bus.memwr | bus.memrd;
	assign stack_sel  = ctrl_q.f.stack_on & bus.stack & mem_cycle;
	assign window_sel = ctrl_q.f.window_on & window_hit & mem_cycle;

	assign stack_pg  = page_t'(ctrl_q.f.stack_page) + page_t'(1);
	assign window_pg = page_t'(ctrl_q.f.window_page) + page_t'(1);

	// Stack wins over the window
	always_comb begin
		if (stack_sel) begin
			page = stack_pg;
		end else if (window_sel) begin
			page = window_pg;
		end else begin
			page = '0;
		end
	end

endmodule

`default_nettype wire

//--- source/vector_mem_pkg.sv
`default_nettype none

package vector_mem_pkg;

`include "vector_mem_params.svh"

	// --------------------
	// Quasi-disk control
	// --------------------

	// Control register as written through port 0x10
	// Read back raw for debug, decoded through the field view
	typedef union packed {
		logic [7:0] raw;
		struct packed {
			logic       high_ext;
			logic       low_ext;
			logic       window_on;
			logic       stack_on;
			logic [1:0] stack_page;
			logic [1:0] window_page;
		} f;
	} kvaz_ctrl_u;

	// --------------------
	// Memory addressing
	// --------------------

	// Page 0 is main RAM, pages 1 to 4 are the RAM disk
	typedef logic [`VM_PAGE_W-1:0] page_t;

	// Flat SRAM byte address
	typedef logic [`VM_SRAM_W-1:0] sram_addr_t;

	// Port number taken from the low address byte on I/O cycles
	typedef logic [7:0] io_port_t;

endpackage

`default_nettype wire

//--- source/vector_mem_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "vector_mem_params.svh"

module vector_mem_top
	import vector_mem_pkg::*;
(
	input  wire                  clk,
	input  wire                  reset,
	input  wire                  clke,
	input  wire [`VM_ADDR_W-1:0] address,
	input  wire [7:0]            wdata,
	input  wire                  memwr,
	input  wire                  memrd,
	input  wire                  stack,
	input  wire                  iowr,
	output logic [7:0]           read_data,
	output logic [7:0]           kvaz_debug
);

	// --------------------
	// CPU bus
	// --------------------

	cpu_bus_if bus ();

	assign bus.clke    = clke;
	assign bus.address = address;
	assign bus.wdata   = wdata;
	assign bus.memwr   = memwr;
	assign bus.memrd   = memrd;
	assign bus.stack   = stack;
	assign bus.iowr    = iowr;

	// Decoder to mapper and memory
	logic  ctrl_load;
	logic  sram_we;
	logic  sram_re;

	// Mapper to memory
	page_t page;

	// --------------------
	// Blocks
	// --------------------

	// Strobes qualified by the active phase
	cpu_bus_decoder u_decoder (
		.clk       (clk),
		.reset     (reset),
		.bus       (bus.decoder),
		.ctrl_load (ctrl_load),
		.sram_we   (sram_we),
		.sram_re   (sram_re)
	);

	// Quasi-disk register and page choice
	ram_disk_mapper u_mapper (
		.clk       (clk),
		.reset     (reset),
		.bus       (bus.mapper),
		.ctrl_load (ctrl_load),
		.page      (page),
		.ctrl      (kvaz_debug)
	);

	// Main RAM and disk pages
	page_sram u_sram (
		.clk       (clk),
		.bus       (bus.memory),
		.page      (page),
		.sram_we   (sram_we),
		.sram_re   (sram_re),
		.read_data (read_data),
		.reset     (reset)
	);

endmodule

`default_nettype wire

//--- src.f
+incdir+include
source/vector_mem_pkg.sv
source/cpu_bus_if.sv
source/cpu_bus_decoder.sv
source/ram_disk_mapper.sv
source/page_sram.sv
source/vector_mem_top.sv
bench/vector_mem_tb.sv
